/* logic/exec_pkg.sv */
////////////////////////////////////////
// Shared definitions for the execute stage
// Widths and constants
// Operation encoding
// Issue, ALU flag, memory request, redirect
// and writeback structs
////////////////////////////////////////

package exec_pkg;

    ////////////////////////////////////////
    // Widths and constants
    ////////////////////////////////////////

    localparam int XLEN        = 32;
    localparam int TAG_W       = 3;
    localparam int SHAMT_W     = 5;
    localparam int BYTE_EN_W   = 4;
    localparam int LINK_OFFSET = 4;
    localparam int OP_W        = 5;

    ////////////////////////////////////////
    // Operation encoding
    ////////////////////////////////////////

    typedef enum logic [OP_W-1:0] {
        // Integer and upper immediate
        NOP, ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA, LUI,
        // Jumps and conditional branches
        JAL, JALR, BEQ, BNE, BLT, BLTU, BGE, BGEU,
        // Loads and stores
        LB, LBU, LH, LHU, LW, SB, SH, SW
    } exec_op_e;

    ////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////

    // Instruction as delivered by decode
    typedef struct packed {
        exec_op_e               operation;
        logic [XLEN-1:0]        pc;
        logic [XLEN-1:0]        operand_a;
        logic [XLEN-1:0]        operand_b;
        // Store data or branch offset
        logic [XLEN-1:0]        operand_c;
        logic [TAG_W-1:0]       tag;
    } issue_t;

    // Adder outputs and compare results from the ALU
    typedef struct packed {
        logic [XLEN-1:0]        sum;
        logic [XLEN-1:0]        sum2;
        logic                   equal;
        logic                   less_than;
        logic                   less_than_unsigned;
        logic                   greater_equal;
        logic                   greater_equal_unsigned;
    } alu_flags_t;

    // Word-aligned data memory request
    typedef struct packed {
        logic [XLEN-1:0]        address;
        logic                   read_enable;
        logic [BYTE_EN_W-1:0]   write_enable;
        logic [XLEN-1:0]        write_data;
    } mem_req_t;

    // Fetch redirect on a taken jump
    typedef struct packed {
        logic                   jump;
        logic [XLEN-1:0]        target;
    } redirect_t;

    // Registered result towards retire
    typedef struct packed {
        logic                   write_enable;
        exec_op_e               operation;
        logic [XLEN-1:0]        result;
    } writeback_t;

endpackage

/* logic/alu.sv */
////////////////////////////////////////
// Integer ALU of the execute stage
// Main and second adder, logic and shifts
// Signed and unsigned compares
// Result select and writeback register
////////////////////////////////////////

`timescale 1ns/1ps

module alu
    import exec_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        stall_i,
    input  issue_t      issue_i,
    input  logic        killed_i,
    output alu_flags_t  flags_o,
    output writeback_t  writeback_o
);

    logic signed [XLEN-1:0] a_signed;
    logic signed [XLEN-1:0] b_signed;
    logic [SHAMT_W-1:0]     shamt;

    logic [XLEN-1:0]        sum2_a;
    logic [XLEN-1:0]        sum2_b;
    logic [XLEN-1:0]        sum;
    logic [XLEN-1:0]        sum2;
    logic [XLEN-1:0]        and_res;
    logic [XLEN-1:0]        or_res;
    logic [XLEN-1:0]        xor_res;
    logic [XLEN-1:0]        sll_res;
    logic [XLEN-1:0]        srl_res;
    logic [XLEN-1:0]        sra_res;

    logic [XLEN-1:0]        result;
    logic                   write_enable;

    logic                   wb_enable_q;
    exec_op_e               wb_op_q;
    logic [XLEN-1:0]        wb_result_q;

    assign a_signed = issue_i.operand_a;
    assign b_signed = issue_i.operand_b;
    assign shamt    = issue_i.operand_b[SHAMT_W-1:0];

    ////////////////////////////////////////
    // Adders
    ////////////////////////////////////////

    // SUB runs on the second adder so the first one stays a plain a+b
    always_comb begin
        sum2_a = (issue_i.operation == SUB) ? issue_i.operand_a : issue_i.pc;
        unique case (issue_i.operation)
            SUB:       sum2_b = -issue_i.operand_b;
            JAL, JALR: sum2_b = XLEN'(LINK_OFFSET);
            default:   sum2_b = issue_i.operand_c;
        endcase
    end

    assign sum  = issue_i.operand_a + issue_i.operand_b;
    assign sum2 = sum2_a + sum2_b;

    ////////////////////////////////////////
    // Logic, shifts and compares
    ////////////////////////////////////////

    assign and_res = issue_i.operand_a & issue_i.operand_b;
    assign or_res  = issue_i.operand_a | issue_i.operand_b;
    assign xor_res = issue_i.operand_a ^ issue_i.operand_b;
    assign sll_res = issue_i.operand_a << shamt;
    assign srl_res = issue_i.operand_a >> shamt;
    assign sra_res = a_signed >>> shamt;

    assign flags_o.sum                    = sum;
    assign flags_o.sum2                   = sum2;
    assign flags_o.equal                  = issue_i.operand_a == issue_i.operand_b;
    assign flags_o.less_than              = a_signed < b_signed;
    assign flags_o.less_than_unsigned     = issue_i.operand_a < issue_i.operand_b;
    assign flags_o.greater_equal          = a_signed >= b_signed;
    assign flags_o.greater_equal_unsigned = issue_i.operand_a >= issue_i.operand_b;

    ////////////////////////////////////////
    // Result select
    ////////////////////////////////////////

    always_comb begin
        unique case (issue_i.operation)
            JAL, JALR, SUB: result = sum2;
            SLT:            result = {{(XLEN-1){1'b0}}, flags_o.less_than};
            SLTU:           result = {{(XLEN-1){1'b0}}, flags_o.less_than_unsigned};
            XOR:            result = xor_res;
            OR:             result = or_res;
            AND:            result = and_res;
            SLL:            result = sll_res;
            SRL:            result = srl_res;
            SRA:            result = sra_res;
            LUI:            result = issue_i.operand_b;
            default:        result = sum;
        endcase
    end

    // Stores and branches never write the register file
    always_comb begin
        unique case (issue_i.operation)
            SB, SH, SW,
            BEQ, BNE, BLT, BLTU, BGE, BGEU: write_enable = 1'b0;
            default:                        write_enable = !killed_i;
        endcase
    end

    ////////////////////////////////////////
    // Writeback register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_enable_q <= 1'b0;
            wb_op_q     <= NOP;
        end else if (!stall_i) begin
            wb_enable_q <= write_enable;
            wb_op_q     <= issue_i.operation;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            wb_result_q <= result;
        end
    end

    assign writeback_o.write_enable = wb_enable_q;
    assign writeback_o.operation    = wb_op_q;
    assign writeback_o.result       = wb_result_q;

endmodule

/* logic/branch_unit.sv */
////////////////////////////////////////
// Branch and tag unit of the execute stage
// Path tag register and kill detection
// Branch condition and jump target
////////////////////////////////////////

`timescale 1ns/1ps

module branch_unit
    import exec_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        stall_i,
    input  issue_t      issue_i,
    input  alu_flags_t  flags_i,
    output logic        killed_o,
    output redirect_t   redirect_o
);

    logic [TAG_W-1:0]   curr_tag;
    logic               killed;
    logic               condition;
    logic               jump;
    logic [XLEN-1:0]    target;

    ////////////////////////////////////////
    // Kill detection
    ////////////////////////////////////////

    // An instruction fetched before the last taken jump still carries
    // the old tag and must not take effect
    assign killed   = curr_tag != issue_i.tag;
    assign killed_o = killed;

    ////////////////////////////////////////
    // Branch decision
    ////////////////////////////////////////

    always_comb begin
        unique case (issue_i.operation)
            BEQ:       condition = flags_i.equal;
            BNE:       condition = !flags_i.equal;
            BLT:       condition = flags_i.less_than;
            BLTU:      condition = flags_i.less_than_unsigned;
            BGE:       condition = flags_i.greater_equal;
            BGEU:      condition = flags_i.greater_equal_unsigned;
            JAL, JALR: condition = 1'b1;
            default:   condition = 1'b0;
        endcase
    end

    assign jump = condition && !killed;

    // Jumps use the main adder, branches use pc plus offset
    always_comb begin
        unique case (issue_i.operation)
            JALR:    target = {flags_i.sum[XLEN-1:1], 1'b0};
            JAL:     target = flags_i.sum;
            default: target = flags_i.sum2;
        endcase
    end

    assign redirect_o.jump   = jump;
    assign redirect_o.target = target;

    ////////////////////////////////////////
    // Path tag
    ////////////////////////////////////////

    // Wraps around, fetch tags its new path with the same count
    always_ff @(posedge clk) begin
        if (reset) begin
            curr_tag <= '0;
        end else if (jump && !stall_i) begin
            curr_tag <= curr_tag + 1'b1;
        end
    end

endmodule

/* logic/mem_request.sv */
////////////////////////////////////////
// Load/store request generation
// Aligned address and read enable
// Byte lanes and replicated store data
////////////////////////////////////////

`timescale 1ns/1ps

module mem_request
    import exec_pkg::*;
(
    input  issue_t      issue_i,
    input  logic        killed_i,
    output mem_req_t    mem_req_o
);

    logic [XLEN-1:0]        eff_addr;
    logic                   is_load;
    logic [BYTE_EN_W-1:0]   lanes;
    logic [XLEN-1:0]        store_data;

    ////////////////////////////////////////
    // Address and read enable
    ////////////////////////////////////////

    // Base plus offset, the bus always sees a word address
    assign eff_addr = issue_i.operand_a + issue_i.operand_b;

    assign is_load = issue_i.operation inside {LB, LBU, LH, LHU, LW};

    ////////////////////////////////////////
    // Byte lanes and store data
    ////////////////////////////////////////

    always_comb begin
        unique case (issue_i.operation)
            // One lane picked by the byte offset
            SB:      lanes = BYTE_EN_W'(1) << eff_addr[1:0];
            // Upper or lower half word
            SH:      lanes = eff_addr[1] ? 4'b1100 : 4'b0011;
            SW:      lanes = '1;
            default: lanes = '0;
        endcase
    end

    // Data is replicated so every enabled lane sees the right bytes
    always_comb begin
        unique case (issue_i.operation)
            SB:      store_data = {BYTE_EN_W{issue_i.operand_c[7:0]}};
            SH:      store_data = {(BYTE_EN_W/2){issue_i.operand_c[15:0]}};
            default: store_data = issue_i.operand_c;
        endcase
    end

    ////////////////////////////////////////
    // Request output
    ////////////////////////////////////////

    // Stale path instructions never reach memory
    assign mem_req_o.address      = {eff_addr[XLEN-1:2], 2'b00};
    assign mem_req_o.read_enable  = is_load && !killed_i;
    assign mem_req_o.write_enable = killed_i ? '0 : lanes;
    assign mem_req_o.write_data   = store_data;

endmodule

/* logic/execute.sv */
////////////////////////////////////////
// Execute stage top level
// ALU with writeback register
// Branch and tag unit
// Memory request unit
////////////////////////////////////////

`timescale 1ns/1ps

module execute
    import exec_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        stall_i,
    input  issue_t      issue_i,
    output logic        killed_o,
    output redirect_t   redirect_o,
    output mem_req_t    mem_req_o,
    output writeback_t  writeback_o
);

    // Adder and compare results shared with the branch unit
    alu_flags_t flags;
    // Tag mismatch seen by all three units
    logic       killed;

    ////////////////////////////////////////
    // Units
    ////////////////////////////////////////

    alu alu_i (
        .clk         (clk),
        .reset       (reset),
        .stall_i     (stall_i),
        .issue_i     (issue_i),
        .killed_i    (killed),
        .flags_o     (flags),
        .writeback_o (writeback_o)
    );

    branch_unit branch_unit_i (
        .clk         (clk),
        .reset       (reset),
        .stall_i     (stall_i),
        .issue_i     (issue_i),
        .flags_i     (flags),
        .killed_o    (killed),
        .redirect_o  (redirect_o)
    );

    mem_request mem_request_i (
        .issue_i     (issue_i),
        .killed_i    (killed),
        .mem_req_o   (mem_req_o)
    );

    assign killed_o = killed;

endmodule

/* verification/execute_sva.sv */
////////////////////////////////////////
// Assertions on the execute stage outputs
// Writeback idle after reset
// Memory enables and kill versus jump
////////////////////////////////////////

`timescale 1ns/1ps

module execute_sva
    import exec_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       killed_o,
    input redirect_t  redirect_o,
    input mem_req_t   mem_req_o,
    input writeback_t writeback_o
);

    // Reset clears the write enable by the next edge
    wb_idle_after_reset: assert property (
        @(posedge clk) reset |=> !writeback_o.write_enable
    ) else $error("writeback write enable high in the cycle after reset");

    // A load never carries byte lanes
    load_without_lanes: assert property (
        @(posedge clk) disable iff (reset)
        mem_req_o.read_enable |-> mem_req_o.write_enable == '0
    ) else $error("byte enables active together with read enable");

    no_jump_when_killed: assert property (
        @(posedge clk) disable iff (reset)
        killed_o |-> !redirect_o.jump
    ) else $error("jump raised for a killed instruction");

endmodule

/* verification/exec_model.svh */
////////////////////////////////////////
// Reference model for the execute stage
// Expected result and register write
// Branch decision and jump target
// Expected memory request
////////////////////////////////////////

`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Value the writeback register should take for one instruction
function automatic logic [XLEN-1:0] calc_result(input issue_t ins);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] res;
    a = ins.operand_a;
    b = ins.operand_b;
    case (ins.operation)
        SUB:       res = a - b;
        SLT:       res = XLEN'($signed(a) < $signed(b));
        SLTU:      res = XLEN'(a < b);
        XOR:       res = a ^ b;
        OR:        res = a | b;
        AND:       res = a & b;
        SLL:       res = a << b[SHAMT_W-1:0];
        SRL:       res = a >> b[SHAMT_W-1:0];
        SRA:       res = $unsigned($signed(a) >>> b[SHAMT_W-1:0]);
        LUI:       res = b;
        // Return address
        JAL, JALR: res = ins.pc + XLEN'(LINK_OFFSET);
        default:   res = a + b;
    endcase
    return res;
endfunction

// Stores and branches leave the register file alone
function automatic logic register_write(input exec_op_e op, input logic killed);
    if (op inside {SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU}) begin
        return 1'b0;
    end
    return !killed;
endfunction

function automatic logic branch_taken(input issue_t ins, input logic killed);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic            taken;
    a = ins.operand_a;
    b = ins.operand_b;
    case (ins.operation)
        BEQ:       taken = a == b;
        BNE:       taken = a != b;
        BLT:       taken = $signed(a) < $signed(b);
        BLTU:      taken = a < b;
        BGE:       taken = $signed(a) >= $signed(b);
        BGEU:      taken = a >= b;
        JAL, JALR: taken = 1'b1;
        default:   taken = 1'b0;
    endcase
    return taken && !killed;
endfunction

function automatic logic [XLEN-1:0] jump_target(input issue_t ins);
    case (ins.operation)
        JALR:    return (ins.operand_a + ins.operand_b) & ~XLEN'(1);
        JAL:     return ins.operand_a + ins.operand_b;
        // Conditional branches are pc relative
        default: return ins.pc + ins.operand_c;
    endcase
endfunction

function automatic mem_req_t memory_request(input issue_t ins, input logic killed);
    logic [XLEN-1:0] addr;
    mem_req_t        req;
    addr = ins.operand_a + ins.operand_b;
    req.address     = addr & ~XLEN'(3);
    req.read_enable = (ins.operation inside {[LB:LW]}) && !killed;
    case (ins.operation)
        SB: begin
            req.write_enable = 4'b0001 << addr[1:0];
            req.write_data   = {BYTE_EN_W{ins.operand_c[7:0]}};
        end
        SH: begin
            req.write_enable = addr[1] ? 4'b1100 : 4'b0011;
            req.write_data   = {2{ins.operand_c[15:0]}};
        end
        SW: begin
            req.write_enable = 4'b1111;
            req.write_data   = ins.operand_c;
        end
        default: begin
            req.write_enable = 4'b0000;
            req.write_data   = ins.operand_c;
        end
    endcase
    if (killed) begin
        req.write_enable = 4'b0000;
    end
    return req;
endfunction

`endif

/* verification/tb_execute.sv */
////////////////////////////////////////
// Testbench for the execute stage
// Clock, reset and seeded random stimulus
// Expected tag and writeback tracking
// Output checks and closing report
////////////////////////////////////////

`timescale 1ns/1ps

module tb_execute
    import exec_pkg::*;
();

    localparam int NUM_INSTR   = 2000;
    // Run length plus a margin of one quarter
    localparam int CYCLE_LIMIT = NUM_INSTR + NUM_INSTR / 4;

    logic       clk;
    logic       reset;
    logic       stall_i;
    issue_t     issue_i;
    logic       killed_o;
    redirect_t  redirect_o;
    mem_req_t   mem_req_o;
    writeback_t writeback_o;

    integer     seed;
    int         error_count = 0;
    int         cycle_count = 0;
    int         jump_count = 0;
    int         kill_count = 0;
    int         stall_count = 0;

    // Expected state and outputs
    logic [TAG_W-1:0] exp_tag;
    logic             exp_killed;
    redirect_t        exp_redirect;
    mem_req_t         exp_mem;
    writeback_t       exp_wb;
    writeback_t       next_wb;

    `include "exec_model.svh"

    execute execute_i (
        .clk         (clk),
        .reset       (reset),
        .stall_i     (stall_i),
        .issue_i     (issue_i),
        .killed_o    (killed_o),
        .redirect_o  (redirect_o),
        .mem_req_o   (mem_req_o),
        .writeback_o (writeback_o)
    );

    bind execute execute_sva execute_sva_i (
        .clk         (clk),
        .reset       (reset),
        .killed_o    (killed_o),
        .redirect_o  (redirect_o),
        .mem_req_o   (mem_req_o),
        .writeback_o (writeback_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic report_mismatch(input string test, input logic [XLEN-1:0] expected,
                                   input logic [XLEN-1:0] actual);
        $display("mismatch %s: expected %h, actual %h", test, expected, actual);
        error_count++;
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic drive_instruction();
        logic [31:0]     pick;
        logic [OP_W-1:0] op_bits;
        issue_t          ins;
        pick = $random(seed);
        op_bits = OP_W'(pick % 28);
        ins.operation = exec_op_e'(op_bits);
        ins.pc        = $random(seed);
        ins.pc[1:0]   = 2'b00;
        ins.operand_a = $random(seed);
        ins.operand_b = $random(seed);
        ins.operand_c = $random(seed);
        pick = $random(seed);
        // Equal operands now and then so BEQ and BGE see both outcomes
        if (pick % 4 == 0) begin
            ins.operand_b = ins.operand_a;
        end
        ins.tag = exp_tag;
        pick = $random(seed);
        if (pick % 8 == 0) begin
            ins.tag = exp_tag + TAG_W'(1 + (pick / 8) % 7);
        end
        pick = $random(seed);
        stall_i = (pick % 6 == 0);
        issue_i = ins;

        exp_killed           = ins.tag != exp_tag;
        exp_redirect.jump    = branch_taken(ins, exp_killed);
        exp_redirect.target  = jump_target(ins);
        exp_mem              = memory_request(ins, exp_killed);
        next_wb.write_enable = register_write(ins.operation, exp_killed);
        next_wb.operation    = ins.operation;
        next_wb.result       = calc_result(ins);
    endtask

    // Called just after the rising edge that took the driven instruction
    task automatic advance_model();
        if (exp_killed) begin
            kill_count++;
        end
        if (stall_i) begin
            stall_count++;
        end else begin
            exp_wb = next_wb;
            if (exp_redirect.jump) begin
                exp_tag = exp_tag + 1'b1;
                jump_count++;
            end
        end
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic check_writeback();
        if (writeback_o.write_enable !== exp_wb.write_enable) begin
            report_mismatch("wb enable", XLEN'(exp_wb.write_enable),
                            XLEN'(writeback_o.write_enable));
        end
        if (writeback_o.operation !== exp_wb.operation) begin
            report_mismatch("wb operation", XLEN'(exp_wb.operation),
                            XLEN'(writeback_o.operation));
        end
        if (exp_wb.write_enable && writeback_o.result !== exp_wb.result) begin
            report_mismatch("wb result", exp_wb.result, writeback_o.result);
        end
    endtask

    task automatic check_outputs();
        if (killed_o !== exp_killed) begin
            report_mismatch("kill", XLEN'(exp_killed), XLEN'(killed_o));
        end
        if (redirect_o.jump !== exp_redirect.jump) begin
            report_mismatch("jump", XLEN'(exp_redirect.jump), XLEN'(redirect_o.jump));
        end
        if (issue_i.operation inside {[JAL:BGEU]} &&
            redirect_o.target !== exp_redirect.target) begin
            report_mismatch("jump target", exp_redirect.target, redirect_o.target);
        end
        if (mem_req_o.read_enable !== exp_mem.read_enable) begin
            report_mismatch("read enable", XLEN'(exp_mem.read_enable),
                            XLEN'(mem_req_o.read_enable));
        end
        if (mem_req_o.write_enable !== exp_mem.write_enable) begin
            report_mismatch("byte lanes", XLEN'(exp_mem.write_enable),
                            XLEN'(mem_req_o.write_enable));
        end
        if (issue_i.operation inside {[LB:SW]} && mem_req_o.address !== exp_mem.address) begin
            report_mismatch("mem address", exp_mem.address, mem_req_o.address);
        end
        if (issue_i.operation inside {SB, SH, SW} &&
            mem_req_o.write_data !== exp_mem.write_data) begin
            report_mismatch("store data", exp_mem.write_data, mem_req_o.write_data);
        end
        check_writeback();
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        seed    = 60421;
        exp_tag = '0;
        exp_wb  = '0;
        reset   = 1'b1;
        stall_i = 1'b0;
        // NOP on tag 0
        issue_i = '0;
        repeat (4) @(posedge clk);
        #1;
        check_writeback();
        if (killed_o !== 1'b0) begin
            report_mismatch("reset kill", XLEN'(1'b0), XLEN'(killed_o));
        end
        if (redirect_o.jump !== 1'b0) begin
            report_mismatch("reset jump", XLEN'(1'b0), XLEN'(redirect_o.jump));
        end
        reset = 1'b0;

        for (int n = 0; n < NUM_INSTR; n++) begin
            drive_instruction();
            #1;
            check_outputs();
            @(posedge clk);
            advance_model();
            #1;
        end
        // Last issued instruction reaches writeback
        check_writeback();

        $display("Run complete: %0d instructions, %0d jumps, %0d killed, %0d stalls, %0d errors",
                 NUM_INSTR, jump_count, kill_count, stall_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+verification
logic/exec_pkg.sv
logic/alu.sv
logic/branch_unit.sv
logic/mem_request.sv
logic/execute.sv
verification/execute_sva.sv
verification/tb_execute.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_execute \
    -Mdir obj_dir \
    -f sources.f

./obj_dir/Vtb_execute | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"
